// File: build.f
design/irq_pkg.sv
design/irq_mtimer.sv
design/irq_arbiter.sv
design/irq_int_controller.sv
design/irq_subsys_top.sv
verif/irq_checker.sv
verif/irq_tb.sv

// File: design/irq_arbiter.sv
// irq_arbiter
// enable and secure mask registers plus highest-id selection
// among the pending level lines, timer line merged in at its id

`timescale 1ns/1ns

module irq_arbiter (
  input  logic                          clk,
  input  logic                          rst_n,
  // software write port
  input  logic                          csr_we_i,
  input  irq_pkg::irq_csr_sel_e         csr_sel_i,
  input  logic [31:0]                   csr_wdata_i,
  // interrupt sources
  input  logic [irq_pkg::IRQ_NUM-1:0]   irq_lines_i,
  input  logic                          timer_irq_i,
  // selected line toward the controller
  output logic                          irq_pending_o,
  output logic [irq_pkg::IRQ_ID_W-1:0]  irq_id_o,
  output logic                          irq_sec_o
);

  import irq_pkg::*;

  logic [IRQ_NUM-1:0]  irq_en_q;
  logic [IRQ_NUM-1:0]  irq_sec_q;
  logic [IRQ_NUM-1:0]  lines_merged;
  logic [IRQ_NUM-1:0]  lines_masked;
  logic [IRQ_ID_W-1:0] sel_id;
  logic                sel_valid;

  ////////////////////////////////////////
  // mask registers
  ////////////////////////////////////////

  // both masks clear on reset, every line starts disabled
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      irq_en_q  <= '0;
      irq_sec_q <= '0;
    end
    else if (csr_we_i)
    begin
      // only the two mask selects belong here
      if (csr_sel_i == CSR_IRQ_EN)
        irq_en_q <= csr_wdata_i;
      if (csr_sel_i == CSR_IRQ_SEC)
        irq_sec_q <= csr_wdata_i;
    end
  end

  ////////////////////////////////////////
  // selection
  ////////////////////////////////////////

  // timer shares its slot with the external line of the same id
  always_comb
  begin
    lines_merged               = irq_lines_i;
    lines_merged[TIMER_IRQ_ID] = irq_lines_i[TIMER_IRQ_ID] | timer_irq_i;
  end

  assign lines_masked = lines_merged & irq_en_q;

  // ascending scan, the last hit is the highest id
  always_comb
  begin
    sel_id    = '0;
    sel_valid = 1'b0;
    for (int i = 0; i < IRQ_NUM; i++)
    begin
      if (lines_masked[i])
      begin
        sel_id    = IRQ_ID_W'(i);
        sel_valid = 1'b1;
      end
    end
  end

  assign irq_pending_o = sel_valid;
  assign irq_id_o      = sel_id;
  // secure tag follows the winner
  assign irq_sec_o     = irq_sec_q[sel_id];

  // a reported winner is a raised and enabled line
  a_sel_legal : assert property (@(posedge clk) disable iff (!rst_n)
    irq_pending_o |-> (lines_merged[irq_id_o] && irq_en_q[irq_id_o]));

endmodule

// File: design/irq_int_controller.sv
// irq_int_controller
// hands one interrupt at a time to the core controller: privilege
// gating, id and secure latch, request/acknowledge/kill handshake

`timescale 1ns/1ns

module irq_int_controller #(
  parameter int unsigned PULP_SECURE = 0
) (
  input  logic                          clk,
  input  logic                          rst_n,
  // selected line from the arbiter
  input  logic                          irq_pending_i,
  input  logic                          irq_sec_i,
  input  logic [irq_pkg::IRQ_ID_W-1:0]  irq_id_i,
  // handshake from the core
  input  logic                          ack_i,
  input  logic                          kill_i,
  // enable bits and privilege from the core status
  input  logic                          m_ie_i,
  input  logic                          u_ie_i,
  input  irq_pkg::priv_lvl_e            priv_lvl_i,
  // request toward the core
  output logic                          irq_req_o,
  output logic                          irq_sec_o,
  output logic [irq_pkg::IRQ_ID_W-1:0]  irq_id_o
);

  import irq_pkg::*;

  irq_ctrl_state_e     state_q;
  logic                irq_gate;
  logic [IRQ_ID_W-1:0] irq_id_q;
  logic                irq_sec_q;

  ////////////////////////////////////////
  // privilege gate
  ////////////////////////////////////////

  generate
    if (PULP_SECURE != 0)
    begin : g_secure
      // user mode takes secure lines even with u_ie low
      assign irq_gate = ((u_ie_i | irq_sec_i) & (priv_lvl_i == PRIV_LVL_U))
                      | (m_ie_i & (priv_lvl_i == PRIV_LVL_M));
    end
    else
    begin : g_plain
      // machine only core, one enable bit
      assign irq_gate = m_ie_i;
    end
  endgenerate

  ////////////////////////////////////////
  // handover state machine
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q   <= IDLE;
      irq_id_q  <= '0;
      irq_sec_q <= 1'b0;
    end
    else
    begin
      case (state_q)
        IDLE:
        begin
          // latch the winner once, line changes after this are ignored
          if (irq_gate && irq_pending_i)
          begin
            state_q   <= IRQ_PENDING;
            irq_id_q  <= irq_id_i;
            irq_sec_q <= irq_sec_i;
          end
        end
        IRQ_PENDING:
        begin
          // ack wins over kill, otherwise hold the request
          if (ack_i)
            state_q <= IRQ_DONE;
          else if (kill_i)
            state_q <= IDLE;
        end
        IRQ_DONE:
        begin
          // one recovery cycle before arbitration resumes
          irq_sec_q <= 1'b0;
          state_q   <= IDLE;
        end
        default:
        begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  assign irq_req_o = (state_q == IRQ_PENDING);
  assign irq_id_o  = irq_id_q;
  assign irq_sec_o = irq_sec_q;

  // id and secure flag hold while the core has not answered
  a_req_stable : assert property (@(posedge clk) disable iff (!rst_n)
    (irq_req_o && !ack_i && !kill_i) |=> ($stable(irq_id_o) && $stable(irq_sec_o)));

  // an acknowledged request is gone in the following cycle
  a_ack_drop : assert property (@(posedge clk) disable iff (!rst_n)
    (irq_req_o && ack_i) |=> !irq_req_o);

endmodule

// File: design/irq_mtimer.sv
// irq_mtimer
// prescaled machine time counter with a compare register
// raises a level timer interrupt while mtime >= mtimecmp

`timescale 1ns/1ns

module irq_mtimer #(
  parameter int unsigned MTIME_PRESCALE = 1
) (
  input  logic                  clk,
  input  logic                  rst_n,
  // software write port
  input  logic                  csr_we_i,
  input  irq_pkg::irq_csr_sel_e csr_sel_i,
  input  logic [31:0]           csr_wdata_i,
  // level interrupt toward the arbiter
  output logic                  timer_irq_o
);

  import irq_pkg::*;

  // prescale counter wide enough to hold MTIME_PRESCALE itself
  localparam int unsigned PS_W = $clog2(MTIME_PRESCALE + 1);
  localparam logic [PS_W-1:0] PS_MAX = PS_W'(MTIME_PRESCALE - 1);

  logic [PS_W-1:0] presc_q;
  logic [31:0]     mtime_q;
  logic [31:0]     mtimecmp_q;
  logic            timer_irq_q;

  ////////////////////////////////////////
  // time base
  ////////////////////////////////////////

  // a software load of mtime restarts the prescaler too
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      presc_q <= '0;
      mtime_q <= '0;
    end
    else if (csr_we_i && (csr_sel_i == CSR_MTIME))
    begin
      presc_q <= '0;
      mtime_q <= csr_wdata_i;
    end
    else if (presc_q == PS_MAX)
    begin
      // one tick every MTIME_PRESCALE cycles
      presc_q <= '0;
      mtime_q <= mtime_q + 32'd1;
    end
    else
    begin
      presc_q <= presc_q + 1'b1;
    end
  end

  // all ones compare value keeps the timer quiet after reset
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      mtimecmp_q <= '1;
    else if (csr_we_i && (csr_sel_i == CSR_MTIMECMP))
      mtimecmp_q <= csr_wdata_i;
  end

  // registered compare stays high until mtimecmp moves past mtime
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      timer_irq_q <= 1'b0;
    else
      timer_irq_q <= (mtime_q >= mtimecmp_q);
  end

  assign timer_irq_o = timer_irq_q;

  // prescaler wraps before it passes its terminal count
  a_presc_range : assert property (@(posedge clk) disable iff (!rst_n)
    presc_q <= PS_MAX);

endmodule

// File: design/irq_pkg.sv
// irq_pkg
// shared types and constants of the interrupt front end: privilege
// levels, controller states, software register selects, line widths

package irq_pkg;

  ////////////////////////////////////////
  // interrupt line geometry
  ////////////////////////////////////////

  // number of level-triggered lines, fixed by the core
  localparam int unsigned IRQ_NUM  = 32;
  // width of an interrupt id
  localparam int unsigned IRQ_ID_W = 5;
  // line taken over by the machine timer
  localparam int unsigned TIMER_IRQ_ID = 7;

  ////////////////////////////////////////
  // privilege and controller state
  ////////////////////////////////////////

  // current privilege level as seen by the core, riscv encoding
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

  // handover state machine toward the core controller
  typedef enum logic [1:0] {
    IDLE        = 2'd0,
    IRQ_PENDING = 2'd1,
    IRQ_DONE    = 2'd2
  } irq_ctrl_state_e;

  // software write port register select, broadcast to all blocks
  typedef enum logic [1:0] {
    CSR_IRQ_EN   = 2'd0,
    CSR_IRQ_SEC  = 2'd1,
    CSR_MTIMECMP = 2'd2,
    CSR_MTIME    = 2'd3
  } irq_csr_sel_e;

endpackage

// File: design/irq_subsys_top.sv
// irq_subsys_top
// interrupt front end: machine timer, mask and priority arbiter,
// and the handover controller toward the core

`timescale 1ns/1ns

module irq_subsys_top #(
  parameter int unsigned PULP_SECURE    = 0,
  parameter int unsigned MTIME_PRESCALE = 1
) (
  input  logic                          clk,
  input  logic                          rst_n,
  // software write port, broadcast to timer and arbiter
  input  logic                          csr_we_i,
  input  irq_pkg::irq_csr_sel_e         csr_sel_i,
  input  logic [31:0]                   csr_wdata_i,
  // external level lines
  input  logic [irq_pkg::IRQ_NUM-1:0]   irq_lines_i,
  // core status
  input  logic                          m_ie_i,
  input  logic                          u_ie_i,
  input  irq_pkg::priv_lvl_e            priv_lvl_i,
  // core handshake
  input  logic                          ack_i,
  input  logic                          kill_i,
  output logic                          irq_req_o,
  output logic [irq_pkg::IRQ_ID_W-1:0]  irq_id_o,
  output logic                          irq_sec_o
);

  import irq_pkg::*;

  logic                timer_irq;
  logic                irq_pending;
  logic [IRQ_ID_W-1:0] irq_id;
  logic                irq_sec;

  ////////////////////////////////////////
  // sources and selection
  ////////////////////////////////////////

  irq_mtimer #(
    .MTIME_PRESCALE (MTIME_PRESCALE)
  ) u_mtimer (
    .clk         (clk),
    .rst_n       (rst_n),
    .csr_we_i    (csr_we_i),
    .csr_sel_i   (csr_sel_i),
    .csr_wdata_i (csr_wdata_i),
    .timer_irq_o (timer_irq)
  );

  irq_arbiter u_arbiter (
    .clk           (clk),
    .rst_n         (rst_n),
    .csr_we_i      (csr_we_i),
    .csr_sel_i     (csr_sel_i),
    .csr_wdata_i   (csr_wdata_i),
    .irq_lines_i   (irq_lines_i),
    .timer_irq_i   (timer_irq),
    .irq_pending_o (irq_pending),
    .irq_id_o      (irq_id),
    .irq_sec_o     (irq_sec)
  );

  ////////////////////////////////////////
  // handover to the core
  ////////////////////////////////////////

  irq_int_controller #(
    .PULP_SECURE (PULP_SECURE)
  ) u_int_controller (
    .clk           (clk),
    .rst_n         (rst_n),
    .irq_pending_i (irq_pending),
    .irq_sec_i     (irq_sec),
    .irq_id_i      (irq_id),
    .ack_i         (ack_i),
    .kill_i        (kill_i),
    .m_ie_i        (m_ie_i),
    .u_ie_i        (u_ie_i),
    .priv_lvl_i    (priv_lvl_i),
    .irq_req_o     (irq_req_o),
    .irq_sec_o     (irq_sec_o),
    .irq_id_o      (irq_id_o)
  );

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the interrupt front end testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  -f build.f --top-module irq_tb -o irq_sim

./obj_dir/irq_sim | tee sim.log

if grep -q "^RESULT: PASS$" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed, see sim.log"
  exit 1
fi

// File: verif/irq_checker.sv
// irq_checker
// watches the interrupt front end ports, compares them with the expected
// values handed over by the testbench and checks the core handshake

`timescale 1ns/1ns

module irq_checker (
  input  logic                          clk,
  input  logic                          rst_n,
  // DUT core-side ports
  input  logic                          irq_req_i,
  input  logic [irq_pkg::IRQ_ID_W-1:0]  irq_id_i,
  input  logic                          irq_sec_i,
  input  logic                          ack_i,
  input  logic                          kill_i,
  // controller state, only for the error lines
  input  irq_pkg::irq_ctrl_state_e      state_i,
  // expectation from the testbench
  input  logic                          exp_valid_i,
  input  logic                          exp_req_i,
  input  logic [irq_pkg::IRQ_ID_W-1:0]  exp_id_i,
  input  logic                          exp_sec_i,
  // running counts
  output int                            value_errs_o,
  output int                            hs_errs_o,
  output int                            checks_o
);

  import irq_pkg::*;

  int                  value_errs = 0;
  int                  hs_errs    = 0;
  int                  checks     = 0;
  // core-side signals seen at the previous edge
  logic                prev_req;
  logic                prev_ack;
  logic                prev_kill;
  logic                prev_sec;
  logic [IRQ_ID_W-1:0] prev_id;

  assign value_errs_o = value_errs;
  assign hs_errs_o    = hs_errs;
  assign checks_o     = checks;

  task automatic report_value(input string name, input logic [31:0] exp_val,
                              input logic [31:0] act_val);
    $display("Error at %0t: %s expected 0x%0h, actual 0x%0h, controller in %s",
             $time, name, exp_val, act_val, state_i.name());
    value_errs++;
  endtask

  task automatic report_handshake(input string what);
    $display("handshake violation at %0t: %s", $time, what);
    hs_errs++;
  endtask

  ////////////////////////////////////////
  // expected values
  ////////////////////////////////////////

  // sampled at the rising edge, outputs still hold the previous cycle
  always @(posedge clk)
  begin
    if (rst_n && exp_valid_i)
    begin
      checks++;
      if (irq_req_i !== exp_req_i)
        report_value("irq_req_o", 32'(exp_req_i), 32'(irq_req_i));
      if (irq_id_i !== exp_id_i)
        report_value("irq_id_o", 32'(exp_id_i), 32'(irq_id_i));
      if (irq_sec_i !== exp_sec_i)
        report_value("irq_sec_o", 32'(exp_sec_i), 32'(irq_sec_i));
    end
  end

  ////////////////////////////////////////
  // request/acknowledge/kill rule
  ////////////////////////////////////////

  always @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      prev_req  <= 1'b0;
      prev_ack  <= 1'b0;
      prev_kill <= 1'b0;
      prev_sec  <= 1'b0;
      prev_id   <= '0;
    end
    else
    begin
      // unanswered request must hold with the same id and flag
      if (prev_req && !prev_ack && !prev_kill)
      begin
        if (!irq_req_i)
          report_handshake("request dropped without ack or kill");
        else if ((irq_id_i != prev_id) || (irq_sec_i != prev_sec))
          report_handshake("id or secure flag changed while the request waited");
      end
      if (prev_req && prev_ack && irq_req_i)
        report_handshake("request still high in the cycle after an ack");
      prev_req  <= irq_req_i;
      prev_ack  <= ack_i;
      prev_kill <= kill_i;
      prev_sec  <= irq_sec_i;
      prev_id   <= irq_id_i;
    end
  end

endmodule

// File: verif/irq_patterns.txt
# columns: we sel wdata lines m_ie u_ie priv ack kill | wait chk | exp_req exp_id exp_sec
# hex except wait and exp_id (decimal); sel 0 en 1 sec 2 mtimecmp 3 mtime; priv 0 user 3 machine
# reset state, lines raised but masks still zero
0 0 00000000 000000ff 1 0 3 0 0 3 1 0 0 0
# priority and masking, enable 2 4 20
1 0 00100014 000000ff 1 0 3 0 0 1 1 0 0 0
0 0 00000000 000000ff 1 0 3 0 0 1 1 1 4 0
0 0 00000000 000000ff 1 0 3 1 0 1 1 0 4 0
0 0 00000000 001000ff 1 0 3 0 0 1 1 0 4 0
0 0 00000000 001000ff 1 0 3 0 0 1 1 1 20 0
# kill, same line requests again one edge later
0 0 00000000 001000ff 1 0 3 0 1 1 1 0 20 0
0 0 00000000 001000ff 1 0 3 0 0 1 1 1 20 0
# ack and kill together, ack wins
0 0 00000000 001000ff 1 0 3 1 1 1 1 0 20 0
0 0 00000000 001000ff 1 0 3 0 0 1 1 0 20 0
0 0 00000000 00000000 1 0 3 0 0 1 1 0 20 0
# hold without ack, higher line ignored, ack then re-request
0 0 00000000 00000010 1 0 3 0 0 1 1 1 4 0
0 0 00000000 00000010 1 0 3 0 0 5 1 1 4 0
0 0 00000000 00100010 1 0 3 0 0 3 1 1 4 0
0 0 00000000 00100010 1 0 3 1 0 1 1 0 4 0
0 0 00000000 00100010 1 0 3 0 0 1 1 0 4 0
0 0 00000000 00100010 1 0 3 0 0 1 1 1 20 0
0 0 00000000 00000000 1 0 3 0 1 2 1 0 20 0
# secure mask bit 2, user mode with u_ie low
1 1 00000004 00000000 1 0 3 0 0 1 1 0 20 0
0 0 00000000 00000010 1 0 0 0 0 3 1 0 20 0
0 0 00000000 00000004 1 0 0 0 0 1 1 1 2 1
0 0 00000000 00000004 1 0 0 1 0 1 1 0 2 1
0 0 00000000 00000000 1 0 0 0 0 1 1 0 2 0
0 0 00000000 00000000 1 0 0 0 0 1 1 0 2 0
0 0 00000000 00000010 1 1 0 0 0 1 1 1 4 0
0 0 00000000 00000000 1 1 0 0 1 2 1 0 4 0
# machine mode, m_ie alone gates
0 0 00000000 00000004 0 1 3 0 0 3 1 0 4 0
0 0 00000000 00000004 1 1 3 0 0 1 1 1 2 1
0 0 00000000 00000000 1 1 3 1 0 3 1 0 2 0
# timer on id 7, mtime 0 and mtimecmp 3 at prescale 4
1 0 00000080 00000000 1 0 3 0 0 1 1 0 2 0
1 3 00000000 00000000 1 0 3 0 0 1 1 0 2 0
1 2 00000003 00000000 1 0 3 0 0 1 1 0 2 0
0 0 00000000 00000000 1 0 3 0 0 12 1 0 2 0
0 0 00000000 00000000 1 0 3 0 0 1 1 1 7 0
# compare moved forward, no request after the ack
1 2 00001000 00000000 1 0 3 0 0 1 1 1 7 0
0 0 00000000 00000000 1 0 3 1 0 1 1 0 7 0
0 0 00000000 00000000 1 0 3 0 0 6 1 0 7 0

// File: verif/irq_tb.sv
// irq_tb
// testbench of the interrupt front end: clock, reset, pattern driven
// stimulus on falling edges, core-side ack/kill pulses and run timeout

`timescale 1ns/1ns

module irq_tb;

  import irq_pkg::*;

  localparam int MAX_STEPS    = 64;
  localparam int RESET_CYCLES = 2;
  localparam int MARGIN       = 50;

  logic                clk;
  logic                rst_n;
  logic                csr_we;
  irq_csr_sel_e        csr_sel;
  logic [31:0]         csr_wdata;
  logic [IRQ_NUM-1:0]  irq_lines;
  logic                m_ie;
  logic                u_ie;
  priv_lvl_e           priv_lvl;
  logic                ack;
  logic                kill;
  logic                irq_req;
  logic [IRQ_ID_W-1:0] irq_id;
  logic                irq_sec;

  // expectation toward the checker
  logic                exp_valid;
  logic                exp_req;
  logic [IRQ_ID_W-1:0] exp_id;
  logic                exp_sec;
  int                  value_errs;
  int                  hs_errs;
  int                  checks;

  // step table loaded from the pattern file
  logic                st_we    [MAX_STEPS];
  logic [1:0]          st_sel   [MAX_STEPS];
  logic [31:0]         st_wdata [MAX_STEPS];
  logic [31:0]         st_lines [MAX_STEPS];
  logic                st_mie   [MAX_STEPS];
  logic                st_uie   [MAX_STEPS];
  logic [1:0]          st_priv  [MAX_STEPS];
  logic                st_ack   [MAX_STEPS];
  logic                st_kill  [MAX_STEPS];
  int                  st_wait  [MAX_STEPS];
  logic                st_chk   [MAX_STEPS];
  logic                st_req   [MAX_STEPS];
  logic [IRQ_ID_W-1:0] st_id    [MAX_STEPS];
  logic                st_sec   [MAX_STEPS];
  int                  n_steps      = 0;
  int                  n_checks     = 0;
  int                  limit_cycles = 0;
  int                  cycle_cnt    = 0;
  bit                  load_ok;

  irq_subsys_top #(
    .PULP_SECURE    (1),
    .MTIME_PRESCALE (4)
  ) UUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .csr_we_i    (csr_we),
    .csr_sel_i   (csr_sel),
    .csr_wdata_i (csr_wdata),
    .irq_lines_i (irq_lines),
    .m_ie_i      (m_ie),
    .u_ie_i      (u_ie),
    .priv_lvl_i  (priv_lvl),
    .ack_i       (ack),
    .kill_i      (kill),
    .irq_req_o   (irq_req),
    .irq_id_o    (irq_id),
    .irq_sec_o   (irq_sec)
  );

  irq_checker u_check (
    .clk          (clk),
    .rst_n        (rst_n),
    .irq_req_i    (irq_req),
    .irq_id_i     (irq_id),
    .irq_sec_i    (irq_sec),
    .ack_i        (ack),
    .kill_i       (kill),
    .state_i      (UUT.u_int_controller.state_q),
    .exp_valid_i  (exp_valid),
    .exp_req_i    (exp_req),
    .exp_id_i     (exp_id),
    .exp_sec_i    (exp_sec),
    .value_errs_o (value_errs),
    .hs_errs_o    (hs_errs),
    .checks_o     (checks)
  );

  // 4 ns clock
  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  ////////////////////////////////////////
  // pattern loading
  ////////////////////////////////////////

  task automatic load_patterns(output bit ok);
    int          fd;
    int          n;
    int          wait_sum;
    string       line;
    logic [31:0] t_we, t_sel, t_wdata, t_lines, t_mie, t_uie, t_priv;
    logic [31:0] t_ack, t_kill, t_wait, t_chk, t_req, t_id, t_sec;
    ok       = 1'b0;
    wait_sum = 0;
    fd = $fopen("verif/irq_patterns.txt", "r");
    if (fd != 0)
    begin
      ok = 1'b1;
      while (!$feof(fd) && (n_steps < MAX_STEPS))
      begin
        line = "";
        void'($fgets(line, fd));
        // blank lines and # comments carry no step
        if ((line.len() > 1) && (line[0] != "#"))
        begin
          n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %d %h %h %d %h",
                      t_we, t_sel, t_wdata, t_lines, t_mie, t_uie, t_priv,
                      t_ack, t_kill, t_wait, t_chk, t_req, t_id, t_sec);
          if (n == 14)
          begin
            st_we[n_steps]    = t_we[0];
            st_sel[n_steps]   = t_sel[1:0];
            st_wdata[n_steps] = t_wdata;
            st_lines[n_steps] = t_lines;
            st_mie[n_steps]   = t_mie[0];
            st_uie[n_steps]   = t_uie[0];
            st_priv[n_steps]  = t_priv[1:0];
            st_ack[n_steps]   = t_ack[0];
            st_kill[n_steps]  = t_kill[0];
            st_wait[n_steps]  = (t_wait == 0) ? 1 : t_wait;
            st_chk[n_steps]   = t_chk[0];
            st_req[n_steps]   = t_req[0];
            st_id[n_steps]    = t_id[IRQ_ID_W-1:0];
            st_sec[n_steps]   = t_sec[0];
            wait_sum          = wait_sum + st_wait[n_steps];
            n_checks          = n_checks + int'(t_chk[0]);
            n_steps++;
          end
          else
          begin
            $display("pattern line could not be parsed: %s", line);
            ok = 1'b0;
          end
        end
      end
      $fclose(fd);
    end
    if (n_steps == 0)
      ok = 1'b0;
    // timeout limit follows the length of the tests
    limit_cycles = wait_sum + MARGIN;
  endtask

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  // levels for the whole step, write and core answer as one-cycle pulses
  task automatic drive_step(input int k);
    csr_we    = st_we[k];
    csr_sel   = irq_csr_sel_e'(st_sel[k]);
    csr_wdata = st_wdata[k];
    irq_lines = st_lines[k];
    m_ie      = st_mie[k];
    u_ie      = st_uie[k];
    priv_lvl  = priv_lvl_e'(st_priv[k]);
    ack       = st_ack[k];
    kill      = st_kill[k];
  endtask

  task automatic release_pulses();
    csr_we    = 1'b0;
    ack       = 1'b0;
    kill      = 1'b0;
    exp_valid = 1'b0;
  endtask

  initial
  begin
    rst_n     = 1'b0;
    csr_we    = 1'b0;
    csr_sel   = CSR_IRQ_EN;
    csr_wdata = '0;
    irq_lines = '0;
    m_ie      = 1'b0;
    u_ie      = 1'b0;
    priv_lvl  = PRIV_LVL_M;
    ack       = 1'b0;
    kill      = 1'b0;
    exp_valid = 1'b0;
    exp_req   = 1'b0;
    exp_id    = '0;
    exp_sec   = 1'b0;
    load_patterns(load_ok);
    if (!load_ok)
    begin
      $display("pattern file verif/irq_patterns.txt is missing or unreadable");
      $display("RESULT: FAIL");
      $finish;
    end
    else
    begin
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      for (int k = 0; k < n_steps; k++)
      begin
        drive_step(k);
        repeat (st_wait[k])
        begin
          @(posedge clk);
          @(negedge clk);
          release_pulses();
        end
        // checker compares at the next rising edge
        if (st_chk[k])
        begin
          exp_req   = st_req[k];
          exp_id    = st_id[k];
          exp_sec   = st_sec[k];
          exp_valid = 1'b1;
        end
      end
      @(posedge clk);
      @(negedge clk);
      release_pulses();
      $display("checks %0d of %0d, value errors %0d, handshake errors %0d",
               checks, n_checks, value_errs, hs_errs);
      if ((value_errs == 0) && (hs_errs == 0) && (checks == n_checks))
        $display("RESULT: PASS");
      else
        $display("RESULT: FAIL");
      $finish;
    end
  end

  // cycle counter, ends a run that never reaches its closing line
  initial
  begin
    wait (limit_cycles > 0);
    while (cycle_cnt < limit_cycles)
    begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout: test did not finish within %0d cycles", limit_cycles);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule
